// ==== list.f ====
src/isa_pkg.sv
src/pipe_pkg.sv
src/register_file.sv
src/fetch_unit.sv
src/decode_unit.sv
src/execute_unit.sv
src/core_top.sv
test/tb_memory.sv
test/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module core_tb -f list.f -o core_sim \
  && ./obj_dir/core_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -qx "TESTS PASSED" sim.log && exit 0 || exit 1

// ==== test/core_tb.sv ====
// Testbench for the four-stage RV32I subset core
// Builds a program from encoders, runs an architectural model of it and
// checks the core's stores, handshakes and trap with concurrent assertions
`timescale 1ns/1ps

module core_tb;

  logic                 clock = 1'b0;
  logic                 reset = 1'b1;
  pipe_pkg::ins_req_t   ins_req;
  pipe_pkg::data_req_t  data_req;
  logic                 ins_ready, data_ready, trap;
  logic [31:0]          ins_data, data_rdata;
  logic [31:0]          exp_addr [0:31];  // Model stores in program order
  logic [31:0]          exp_data [0:31];
  int                   exp_n = 0;
  int                   st_idx = 0;       // Stores seen from the core
  int                   cyc = 0;
  int                   errors = 0;
  int                   hold_errors = 0;  // Handshake stability over the whole run
  int                   failed_tests = 0;
  int                   n = 0;
  logic                 seen_req = 1'b0;

  always #20 clock = ~clock;

  core_top #(.reset_pc(32'h0)) uut (
    .clock(clock), .reset(reset), .ins_req(ins_req), .ins_ready(ins_ready),
    .ins_data(ins_data), .data_req(data_req), .data_ready(data_ready),
    .data_rdata(data_rdata), .trap(trap)
  );

  tb_memory mem (
    .clock(clock), .reset(reset), .ins_req(ins_req), .ins_ready(ins_ready),
    .ins_data(ins_data), .data_req(data_req), .data_ready(data_ready),
    .data_rdata(data_rdata)
  );

  always @(posedge clock) begin
    cyc <= cyc + 1;
    if (!reset && ins_req.valid)
      seen_req <= 1'b1;
    if (!reset && data_req.valid && data_ready && data_req.write)
      st_idx <= st_idx + 1;
  end

  // ==========================================================================
  // Assertions
  // ==========================================================================
  a_reset: assert property (@(posedge clock) (reset && cyc > 0) |->
      (!ins_req.valid && !data_req.valid && !trap))
    else begin
      errors++;
      $display("FAILED %0t: in reset ins_req.valid %b data_req.valid %b trap %b expected 0",
               $time, $sampled(ins_req.valid), $sampled(data_req.valid), $sampled(trap));
    end

  a_first: assert property (@(posedge clock) disable iff (reset)
      (ins_req.valid && !seen_req) |-> ins_req.addr == 32'h0)
    else begin
      errors++;
      $display("FAILED %0t: ins_req.addr got %h expected 00000000", $time,
               $sampled(ins_req.addr));
    end

  a_ins_hold: assert property (@(posedge clock) disable iff (reset)
      (ins_req.valid && !ins_ready) |=> $stable(ins_req))
    else begin
      hold_errors++;
      $display("FAILED %0t: ins_req got %h expected %h", $time,
               $sampled(ins_req), $past(ins_req));
    end

  a_data_hold: assert property (@(posedge clock) disable iff (reset)
      (data_req.valid && !data_ready) |=> $stable(data_req))
    else begin
      hold_errors++;
      $display("FAILED %0t: data_req got %h expected %h", $time,
               $sampled(data_req), $past(data_req));
    end

  a_store: assert property (@(posedge clock) disable iff (reset)
      (data_req.valid && data_ready && data_req.write) |->
      (st_idx < exp_n && data_req.addr == exp_addr[st_idx] &&
       data_req.wdata == exp_data[st_idx]))
    else begin
      errors++;
      $display("FAILED %0t: store %0d data_req.addr got %h expected %h, wdata got %h expected %h",
               $time, $sampled(st_idx), $sampled(data_req.addr), exp_addr[$sampled(st_idx)],
               $sampled(data_req.wdata), exp_data[$sampled(st_idx)]);
    end

  a_trap_fetch: assert property (@(posedge clock) disable iff (reset)
      (trap && !ins_req.valid) |=> !ins_req.valid)
    else begin
      errors++;
      $display("FAILED %0t: ins_req.valid got 1 expected 0 after trap", $time);
    end

  a_trap_data: assert property (@(posedge clock) disable iff (reset)
      trap |-> !data_req.valid)
    else begin
      errors++;
      $display("FAILED %0t: data_req.valid got 1 expected 0 after trap", $time);
    end

  a_trap_stores: assert property (@(posedge clock) disable iff (reset)
      $rose(trap) |-> st_idx == exp_n)
    else begin
      errors++;
      $display("FAILED %0t: st_idx got %0d expected %0d at trap", $time,
               $sampled(st_idx), exp_n);
    end

  // ==========================================================================
  // Encoders and program
  // ==========================================================================
  function automatic logic [31:0] op_r(int f3, int f7, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] op_i(int opc, int f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] op_s(int rs1, int rs2, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] op_b(int f3, int rs1, int rs2, int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] op_j(int rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic logic [31:0] fill_word(int addr);
    return (addr * 32'h9e3779b1) ^ 32'h5a5a0000;  // Differs for every address
  endfunction

  task automatic put(logic [31:0] w);
    mem.rom[n] = w;
    n++;
  endtask

  task automatic load_program;
    for (int i = 0; i < 64; i++) begin
      mem.rom[i] = 32'h0;                  // Zero word is illegal
      mem.ram[i] = fill_word(i * 4);
    end
    put({20'h12345, 5'd1, 7'h37});         // LUI x1
    put(op_i(7'h13, 0, 2, 1, 12'h678));    // ADDI x2, x1
    put(op_r(0, 0, 3, 2, 1));              // ADD
    put(op_r(0, 32, 4, 3, 2));             // SUB
    put(op_r(4, 0, 5, 4, 3));              // XOR
    put(op_r(6, 0, 6, 5, 2));              // OR
    put(op_r(7, 0, 7, 6, 3));              // AND
    put(op_r(2, 0, 8, 4, 3));              // SLT
    put(op_i(7'h13, 0, 9, 0, 5));          // Shift amount
    put(op_r(1, 0, 10, 2, 9));             // SLL
    put(op_r(5, 0, 11, 3, 9));             // SRL
    put(op_i(7'h13, 7, 12, 3, 12'h0ff));   // ANDI
    put(op_i(7'h13, 6, 13, 12, -16));      // ORI
    put(op_i(7'h13, 4, 14, 13, 12'h055));  // XORI
    put(op_i(7'h13, 2, 15, 14, 7));        // SLTI
    put(op_s(0, 4, 0));
    put(op_s(0, 7, 4));
    put(op_s(0, 8, 8));
    put(op_s(0, 10, 12));
    put(op_s(0, 11, 16));
    put(op_s(0, 15, 20));
    // Loads and stores
    put(op_i(7'h03, 2, 16, 0, 0));
    put(op_i(7'h03, 2, 17, 0, 4));
    put(op_r(0, 0, 18, 16, 17));           // Load-use
    put(op_s(0, 18, 24));
    put(op_i(7'h03, 2, 19, 0, 100));       // Untouched RAM word
    put(op_s(0, 19, 28));
    // Control flow where skipped slots store to 200 and above
    put(op_b(0, 16, 4, 8));                // BEQ taken
    put(op_s(0, 1, 200));
    put(op_b(1, 16, 4, 8));                // BNE not taken
    put(op_s(0, 5, 32));
    put(op_b(1, 16, 17, 8));               // BNE taken
    put(op_s(0, 1, 204));
    put(op_b(0, 16, 17, 8));               // BEQ not taken
    put(op_s(0, 6, 36));
    put(op_j(20, 8));                      // JAL x20
    put(op_s(0, 1, 208));
    put(op_s(0, 20, 40));                  // Link value
  endtask

  // ==========================================================================
  // Architectural model
  // ==========================================================================
  task automatic run_model;
    logic [31:0] x [0:31];
    logic [31:0] mram [0:63];
    logic [31:0] w, pc, a, b, imm_i, imm_s, imm_b, imm_j, addr;
    logic        done;
    for (int i = 0; i < 32; i++)
      x[i] = 32'h0;
    for (int i = 0; i < 64; i++)
      mram[i] = fill_word(i * 4);
    pc = 32'h0;
    done = 1'b0;
    for (int step = 0; step < 200 && !done; step++) begin
      w = mem.rom[pc[7:2]];
      a = x[w[19:15]];
      b = x[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      if (w[6:0] == 7'h13 && w[14:12] != 3'd1 && w[14:12] != 3'd3 && w[14:12] != 3'd5)
        b = imm_i;                         // Immediate ALU uses imm as operand B
      case (w[6:0])
        7'h33, 7'h13: begin
          case (w[14:12])
            3'd0: x[w[11:7]] = (w[6:0] == 7'h33 && w[30]) ? a - b : a + b;
            3'd1: x[w[11:7]] = a << b[4:0];
            3'd2: x[w[11:7]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4: x[w[11:7]] = a ^ b;
            3'd5: x[w[11:7]] = a >> b[4:0];
            3'd6: x[w[11:7]] = a | b;
            3'd7: x[w[11:7]] = a & b;
            default: done = 1'b1;
          endcase
        end
        7'h37: x[w[11:7]] = {w[31:12], 12'h0};
        7'h03: begin
          addr = a + imm_i;
          x[w[11:7]] = mram[addr[7:2]];
        end
        7'h23: begin
          addr = a + imm_s;
          mram[addr[7:2]] = b;
          exp_addr[exp_n] = addr;
          exp_data[exp_n] = b;
          exp_n++;
        end
        7'h63: begin
          if ((w[14:12] == 3'd0 && a == b) || (w[14:12] == 3'd1 && a != b))
            pc = pc + imm_b - 32'd4;
        end
        7'h6f: begin
          x[w[11:7]] = pc + 32'd4;
          pc = pc + imm_j - 32'd4;
        end
        default: done = 1'b1;              // Illegal ends the program
      endcase
      x[0] = 32'h0;
      if (!done)
        pc = pc + 32'd4;
    end
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  task automatic wait_stores(int count, int limit);
    int t;
    t = 0;
    while (st_idx < count && t < limit) begin
      @(negedge clock);
      t++;
    end
    if (st_idx < count) begin
      errors++;
      $display("Timed out waiting for store %0d, only %0d seen", count, st_idx);
    end
  endtask

  task automatic finish_test(int num, string name, int errs);
    if (errs == 0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d errors", num, name, errs);
    end
  endtask

  initial begin
    int e;
    int t;
    load_program();
    run_model();
    e = errors;
    repeat (4) @(negedge clock);
    reset = 1'b0;

    t = 0;
    while (!seen_req && t < 20) begin
      @(negedge clock);
      t++;
    end
    if (!seen_req) begin
      errors++;
      $display("No instruction request after reset");
    end
    finish_test(1, "reset and first fetch", errors - e);

    e = errors;
    wait_stores(6, 400);
    finish_test(3, "alu and forwarding", errors - e);
    e = errors;
    wait_stores(8, 300);
    finish_test(4, "load and store", errors - e);
    e = errors;
    wait_stores(exp_n, 400);
    finish_test(5, "control flow", errors - e);

    e = errors;
    t = 0;
    while (!trap && t < 100) begin
      @(negedge clock);
      t++;
    end
    if (!trap) begin
      errors++;
      $display("Trap did not rise after the illegal instruction");
    end
    repeat (50) @(negedge clock);          // Quiet window after trap
    finish_test(6, "illegal instruction", errors - e);
    finish_test(2, "handshake stability", hold_errors);

    $display("tests run 6, tests failed %0d, check errors %0d", failed_tests,
             errors + hold_errors);
    if (errors == 0 && hold_errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== test/tb_memory.sv ====
// Testbench memory model
// Instruction ROM and 64-word data RAM, each port with a random ready delay
// of 0 to 3 cycles per request. Ready changes on the falling edge.
`timescale 1ns/1ps

module tb_memory (
  input  logic                     clock,
  input  logic                     reset,
  input  pipe_pkg::ins_req_t       ins_req,
  output logic                     ins_ready = 1'b0,
  output logic [isa_pkg::xlen-1:0] ins_data,
  input  pipe_pkg::data_req_t      data_req,
  output logic                     data_ready = 1'b0,
  output logic [isa_pkg::xlen-1:0] data_rdata
);

  logic [31:0] rom [0:63];  // Filled by the testbench top
  logic [31:0] ram [0:63];
  int          seed = 48;
  int          ins_cnt = -1;   // Cycles left before ready or -1 with no request seen
  int          data_cnt = -1;
  logic        ins_took = 1'b0;
  logic        data_took = 1'b0;

  assign ins_data   = rom[ins_req.addr[7:2]];
  assign data_rdata = ram[data_req.addr[7:2]];  // Sampled by the core on transfer

  // Transfers and RAM writes on the rising edge
  always @(posedge clock) begin
    ins_took  <= ins_req.valid && ins_ready;
    data_took <= data_req.valid && data_ready;
    if (!reset && data_req.valid && data_ready && data_req.write)
      ram[data_req.addr[7:2]] <= data_req.wdata;
  end

  // ==========================================================================
  // Ready delays
  // ==========================================================================
  always @(negedge clock) begin
    if (reset) begin
      ins_ready  = 1'b0;
      data_ready = 1'b0;
      ins_cnt    = -1;
      data_cnt   = -1;
    end else begin
      if (ins_took)
        ins_cnt = -1;            // Next request gets a fresh delay
      if (data_took)
        data_cnt = -1;
      if (ins_req.valid) begin
        if (ins_cnt < 0)
          ins_cnt = {$random(seed)} % 4;
        else if (ins_cnt > 0)
          ins_cnt = ins_cnt - 1;
      end
      if (data_req.valid) begin
        if (data_cnt < 0)
          data_cnt = {$random(seed)} % 4;
        else if (data_cnt > 0)
          data_cnt = data_cnt - 1;
      end
      ins_ready  = ins_req.valid && ins_cnt == 0;
      data_ready = data_req.valid && data_cnt == 0;
    end
  end

endmodule

// ==== src/core_top.sv ====
// Four-stage RV32I subset core
// Fetch, decode with register read, execute with memory access, writeback.
// Stall and redirect come from execute, trap halts fetch.
`timescale 1ns/1ps

module core_top #(
  parameter logic [isa_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                     clock,
  input  logic                     reset,
  output pipe_pkg::ins_req_t       ins_req,
  input  logic                     ins_ready,
  input  logic [isa_pkg::xlen-1:0] ins_data,
  output pipe_pkg::data_req_t      data_req,
  input  logic                     data_ready,
  input  logic [isa_pkg::xlen-1:0] data_rdata,
  output logic                     trap
);

  pipe_pkg::fetch_pkt_t fetch_pkt;
  pipe_pkg::issue_pkt_t issue_pkt;
  pipe_pkg::wb_pkt_t    wb_pkt;
  pipe_pkg::redirect_t  redirect;
  logic                 stall;

  fetch_unit #(.reset_pc(reset_pc)) fetch (
    .clock     (clock),
    .reset     (reset),
    .stall     (stall),
    .redirect  (redirect),
    .halt      (trap),
    .ins_req   (ins_req),
    .ins_ready (ins_ready),
    .ins_data  (ins_data),
    .fetch_pkt (fetch_pkt)
  );

  decode_unit decode (
    .clock     (clock),
    .reset     (reset),
    .stall     (stall),
    .flush     (redirect.taken),  // Wrong-path instruction in DEC/EX
    .fetch_pkt (fetch_pkt),
    .wb_pkt    (wb_pkt),
    .issue_pkt (issue_pkt)
  );

  execute_unit execute (
    .clock      (clock),
    .reset      (reset),
    .issue_pkt  (issue_pkt),
    .data_req   (data_req),
    .data_ready (data_ready),
    .data_rdata (data_rdata),
    .wb_pkt     (wb_pkt),
    .redirect   (redirect),
    .stall      (stall),
    .trap       (trap)
  );

endmodule

// ==== src/execute_unit.sv ====
// Execute and memory stage
// Forwards writeback results into the operands, runs the ALU, resolves
// BEQ/BNE and JAL, drives the data memory handshake and holds the sticky
// trap flag. Owns the EX/WB register.
`timescale 1ns/1ps

module execute_unit (
  input  logic                     clock,
  input  logic                     reset,
  input  pipe_pkg::issue_pkt_t     issue_pkt,
  output pipe_pkg::data_req_t      data_req,
  input  logic                     data_ready,
  input  logic [isa_pkg::xlen-1:0] data_rdata,
  output pipe_pkg::wb_pkt_t        wb_pkt,
  output pipe_pkg::redirect_t      redirect,
  output logic                     stall,
  output logic                     trap
);

  logic                     live;     // Valid, legal, not trapped
  logic                     mem_op;
  logic                     eq;
  logic [isa_pkg::xlen-1:0] op_a, op_b, rs2_fwd;
  logic [isa_pkg::xlen-1:0] alu_result, result;

  // Writeback result wins on an index match, x0 never forwarded
  function automatic logic [isa_pkg::xlen-1:0] forward(
    input logic [isa_pkg::reg_addr_width-1:0] idx,
    input logic [isa_pkg::xlen-1:0]           reg_data
  );
    if (wb_pkt.valid && wb_pkt.rd != '0 && wb_pkt.rd == idx)
      return wb_pkt.result;
    return reg_data;
  endfunction

  assign live    = issue_pkt.valid && !issue_pkt.illegal && !trap;
  assign op_a    = forward(issue_pkt.rs1, issue_pkt.rs1_data);
  assign rs2_fwd = forward(issue_pkt.rs2, issue_pkt.rs2_data);
  assign op_b    = issue_pkt.use_imm ? issue_pkt.imm : rs2_fwd;
  assign eq      = (op_a == rs2_fwd);

  // ==========================================================================
  // ALU
  // ==========================================================================
  always_comb begin
    case (issue_pkt.alu_op)
      pipe_pkg::alu_add:    alu_result = op_a + op_b;
      pipe_pkg::alu_sub:    alu_result = op_a - op_b;
      pipe_pkg::alu_and:    alu_result = op_a & op_b;
      pipe_pkg::alu_or:     alu_result = op_a | op_b;
      pipe_pkg::alu_xor:    alu_result = op_a ^ op_b;
      pipe_pkg::alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      pipe_pkg::alu_sll:    alu_result = op_a << op_b[4:0];
      pipe_pkg::alu_srl:    alu_result = op_a >> op_b[4:0];
      pipe_pkg::alu_pass_b: alu_result = op_b;
      default:              alu_result = op_a + op_b;
    endcase
  end

  // Writeback value by unit
  always_comb begin
    case (issue_pkt.unit)
      pipe_pkg::unit_load: result = data_rdata;            // Sampled on transfer
      pipe_pkg::unit_jump: result = issue_pkt.pc + 32'd4;  // Link
      default:             result = alu_result;
    endcase
  end

  // ==========================================================================
  // Data memory port, stall and redirect
  // ==========================================================================
  assign mem_op = live && (issue_pkt.unit == pipe_pkg::unit_load ||
                           issue_pkt.unit == pipe_pkg::unit_store);

  always_comb begin
    data_req.valid = mem_op;
    data_req.write = (issue_pkt.unit == pipe_pkg::unit_store);
    data_req.addr  = alu_result;  // rs1 + imm
    data_req.wdata = rs2_fwd;
  end

  assign stall = mem_op && !data_ready;  // Drops in the transfer cycle

  always_comb begin
    redirect.taken = live && ((issue_pkt.unit == pipe_pkg::unit_branch_eq && eq) ||
                              (issue_pkt.unit == pipe_pkg::unit_branch_ne && !eq) ||
                              (issue_pkt.unit == pipe_pkg::unit_jump));
    redirect.target = issue_pkt.pc + issue_pkt.imm;
  end

  // EX/WB register and trap flag
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_pkt.valid <= 1'b0;
      trap         <= 1'b0;
    end else begin
      if (issue_pkt.valid && issue_pkt.illegal)
        trap <= 1'b1;  // Sticky until reset
      if (!stall) begin
        wb_pkt.valid  <= live && issue_pkt.rd_we;
        wb_pkt.rd     <= issue_pkt.rd;
        wb_pkt.result <= result;
      end
    end
  end

endmodule

// ==== src/decode_unit.sv ====
// Decode stage
// Maps opcode and function fields to a unit, an ALU op and flags,
// builds the immediate, flags encodings outside the subset as illegal
// and reads the register file. Owns the DEC/EX register.
`timescale 1ns/1ps

module decode_unit (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 stall,
  input  logic                 flush,
  input  pipe_pkg::fetch_pkt_t fetch_pkt,
  input  pipe_pkg::wb_pkt_t    wb_pkt,
  output pipe_pkg::issue_pkt_t issue_pkt
);

  logic [isa_pkg::xlen-1:0] instr;
  isa_pkg::opcode_e         opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic                     f7_ok;
  logic [isa_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;
  logic [isa_pkg::xlen-1:0] rs1_data, rs2_data;
  pipe_pkg::issue_pkt_t     dec;

  assign instr  = fetch_pkt.instr;
  assign opcode = isa_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Immediate formats
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  register_file regs (
    .clock    (clock),
    .reset    (reset),
    .wb_pkt   (wb_pkt),
    .rs1_addr (instr[19:15]),
    .rs2_addr (instr[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // ==========================================================================
  // Instruction decode
  // ==========================================================================
  always_comb begin
    dec          = '0;
    dec.valid    = fetch_pkt.valid;
    dec.unit     = pipe_pkg::unit_alu;
    dec.alu_op   = pipe_pkg::alu_add;
    dec.rs1      = instr[19:15];
    dec.rs2      = instr[24:20];
    dec.rd       = instr[11:7];
    dec.rs1_data = rs1_data;
    dec.rs2_data = rs2_data;
    dec.imm      = imm_i;
    dec.pc       = fetch_pkt.pc;
    f7_ok        = (funct7 == isa_pkg::f7_base);
    case (opcode)
      isa_pkg::opc_op: begin
        dec.rd_we = 1'b1;
        case (funct3)
          isa_pkg::f3_add_sub: begin
            dec.alu_op = (funct7 == isa_pkg::f7_alt) ? pipe_pkg::alu_sub : pipe_pkg::alu_add;
            f7_ok      = f7_ok || (funct7 == isa_pkg::f7_alt);
          end
          isa_pkg::f3_sll: dec.alu_op = pipe_pkg::alu_sll;
          isa_pkg::f3_slt: dec.alu_op = pipe_pkg::alu_slt;
          isa_pkg::f3_xor: dec.alu_op = pipe_pkg::alu_xor;
          isa_pkg::f3_srl: dec.alu_op = pipe_pkg::alu_srl;  // SRA not supported
          isa_pkg::f3_or:  dec.alu_op = pipe_pkg::alu_or;
          isa_pkg::f3_and: dec.alu_op = pipe_pkg::alu_and;
          default:         dec.illegal = 1'b1;              // SLTU
        endcase
        if (!f7_ok)
          dec.illegal = 1'b1;
      end
      isa_pkg::opc_op_imm: begin
        dec.rd_we   = 1'b1;
        dec.use_imm = 1'b1;
        case (funct3)
          isa_pkg::f3_add_sub: dec.alu_op = pipe_pkg::alu_add;
          isa_pkg::f3_slt:     dec.alu_op = pipe_pkg::alu_slt;
          isa_pkg::f3_xor:     dec.alu_op = pipe_pkg::alu_xor;
          isa_pkg::f3_or:      dec.alu_op = pipe_pkg::alu_or;
          isa_pkg::f3_and:     dec.alu_op = pipe_pkg::alu_and;
          default:             dec.illegal = 1'b1;  // Shifts by imm, SLTIU
        endcase
      end
      isa_pkg::opc_lui: begin
        dec.rd_we   = 1'b1;
        dec.use_imm = 1'b1;
        dec.alu_op  = pipe_pkg::alu_pass_b;
        dec.imm     = imm_u;
      end
      isa_pkg::opc_load: begin
        dec.unit    = pipe_pkg::unit_load;
        dec.rd_we   = 1'b1;
        dec.use_imm = 1'b1;           // Address is rs1 + imm
        dec.illegal = (funct3 != isa_pkg::f3_word);
      end
      isa_pkg::opc_store: begin
        dec.unit    = pipe_pkg::unit_store;
        dec.use_imm = 1'b1;
        dec.imm     = imm_s;
        dec.illegal = (funct3 != isa_pkg::f3_word);
      end
      isa_pkg::opc_branch: begin
        dec.imm = imm_b;
        if (funct3 == isa_pkg::f3_beq)
          dec.unit = pipe_pkg::unit_branch_eq;
        else if (funct3 == isa_pkg::f3_bne)
          dec.unit = pipe_pkg::unit_branch_ne;
        else
          dec.illegal = 1'b1;
      end
      isa_pkg::opc_jal: begin
        dec.unit  = pipe_pkg::unit_jump;
        dec.rd_we = 1'b1;             // Link pc + 4
        dec.imm   = imm_j;
      end
      default: dec.illegal = 1'b1;
    endcase
    if (dec.illegal)
      dec.rd_we = 1'b0;
  end

  // DEC/EX register, held while execute waits on memory
  always_ff @(posedge clock) begin
    if (reset || flush)
      issue_pkt.valid <= 1'b0;
    else if (!stall)
      issue_pkt <= dec;
  end

endmodule

// ==== src/fetch_unit.sv ====
// Fetch stage
// Owns the program counter and the instruction memory handshake.
// A request stays up until its transfer, so a redirect that lands
// mid-fetch marks the returning word for discard. Owns the IF/DEC register.
`timescale 1ns/1ps

module fetch_unit #(
  parameter logic [isa_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     stall,
  input  pipe_pkg::redirect_t      redirect,
  input  logic                     halt,
  output pipe_pkg::ins_req_t       ins_req,
  input  logic                     ins_ready,
  input  logic [isa_pkg::xlen-1:0] ins_data,
  output pipe_pkg::fetch_pkt_t     fetch_pkt
);

  typedef enum logic [1:0] {
    st_idle,     // No request outstanding
    st_wait,     // Request up and word wanted
    st_discard   // Request up but word is stale
  } state_e;

  state_e                   state;
  logic [isa_pkg::xlen-1:0] pc;        // Address of current or next request
  logic [isa_pkg::xlen-1:0] redir_pc;  // Target held while a stale word drains
  logic                     xfer;
  logic                     slot_free;

  // Request straight from state and stable until transfer
  always_comb begin
    ins_req.valid = (state != st_idle);
    ins_req.addr  = pc;
  end

  assign xfer      = ins_req.valid && ins_ready;
  assign slot_free = !fetch_pkt.valid || !stall;  // Empty or taken by decode

  // ==========================================================================
  // PC, request state and IF/DEC register
  // ==========================================================================
  always_ff @(posedge clock) begin
    if (reset) begin
      state           <= st_idle;
      pc              <= reset_pc;
      fetch_pkt.valid <= 1'b0;
    end else if (redirect.taken) begin
      fetch_pkt.valid <= 1'b0;  // Wrong-path word dropped
      if (ins_req.valid && !xfer) begin
        redir_pc <= redirect.target;  // Old request keeps its address
        state    <= st_discard;
      end else begin
        pc    <= redirect.target;
        state <= halt ? st_idle : st_wait;
      end
    end else begin
      if (!stall)
        fetch_pkt.valid <= 1'b0;  // Consumed by decode
      case (state)
        st_idle: begin
          if (!halt && slot_free)
            state <= st_wait;
        end
        st_wait: begin
          if (xfer) begin
            if (slot_free) begin
              fetch_pkt.valid <= 1'b1;
              fetch_pkt.pc    <= pc;
              fetch_pkt.instr <= ins_data;
              pc              <= pc + 32'd4;
              state           <= halt ? st_idle : st_wait;  // Next fetch at once
            end else begin
              state <= st_idle;  // Slot held by stall so the word is refetched
            end
          end
        end
        st_discard: begin
          if (xfer) begin
            pc    <= redir_pc;  // Stale word gone, now fetch the target
            state <= halt ? st_idle : st_wait;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== src/register_file.sv ====
// Integer register file
// 31 writable registers with x0 reading as zero, two read ports.
// A write in the same cycle as a read of that index is passed through.
`timescale 1ns/1ps

module register_file (
  input  logic                               clock,
  input  logic                               reset,
  input  pipe_pkg::wb_pkt_t                  wb_pkt,
  input  logic [isa_pkg::reg_addr_width-1:0] rs1_addr,
  input  logic [isa_pkg::reg_addr_width-1:0] rs2_addr,
  output logic [isa_pkg::xlen-1:0]           rs1_data,
  output logic [isa_pkg::xlen-1:0]           rs2_data
);

  logic [isa_pkg::xlen-1:0] regs [1:31];  // No storage for x0

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;  // Architectural state starts at zero
    end else if (wb_pkt.valid && wb_pkt.rd != '0) begin
      regs[wb_pkt.rd] <= wb_pkt.result;
    end
  end

  // Read with write-through
  always_comb begin
    rs1_data = '0;
    rs2_data = '0;
    if (rs1_addr != '0)
      rs1_data = (wb_pkt.valid && wb_pkt.rd == rs1_addr) ? wb_pkt.result : regs[rs1_addr];
    if (rs2_addr != '0)
      rs2_data = (wb_pkt.valid && wb_pkt.rd == rs2_addr) ? wb_pkt.result : regs[rs2_addr];
  end

endmodule

// ==== src/pipe_pkg.sv ====
// Pipeline micro-op encodings and stage bundles
// Packed structs carried by the stage registers and the memory ports
package pipe_pkg;

  // ==========================================================================
  // Micro-ops
  // ==========================================================================
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll,
    alu_srl,
    alu_pass_b  // LUI, operand B straight through
  } alu_op_e;

  typedef enum logic [2:0] {
    unit_alu,
    unit_load,
    unit_store,
    unit_branch_eq,
    unit_branch_ne,
    unit_jump
  } unit_e;

  // ==========================================================================
  // Stage bundles
  // ==========================================================================
  typedef struct packed {
    logic                    valid;
    logic [isa_pkg::xlen-1:0] pc;
    logic [isa_pkg::xlen-1:0] instr;
  } fetch_pkt_t;

  typedef struct packed {
    logic                               valid;
    logic                               illegal;  // Outside the subset
    unit_e                              unit;
    alu_op_e                            alu_op;
    logic                               use_imm;  // Operand B from imm
    logic                               rd_we;
    logic [isa_pkg::reg_addr_width-1:0] rs1;
    logic [isa_pkg::reg_addr_width-1:0] rs2;
    logic [isa_pkg::reg_addr_width-1:0] rd;
    logic [isa_pkg::xlen-1:0]           rs1_data;
    logic [isa_pkg::xlen-1:0]           rs2_data;
    logic [isa_pkg::xlen-1:0]           imm;
    logic [isa_pkg::xlen-1:0]           pc;
  } issue_pkt_t;

  typedef struct packed {
    logic                               valid;
    logic [isa_pkg::reg_addr_width-1:0] rd;
    logic [isa_pkg::xlen-1:0]           result;
  } wb_pkt_t;

  typedef struct packed {
    logic                     taken;
    logic [isa_pkg::xlen-1:0] target;
  } redirect_t;

  // Memory port requests
  typedef struct packed {
    logic                     valid;
    logic [isa_pkg::xlen-1:0] addr;
  } ins_req_t;

  typedef struct packed {
    logic                     valid;
    logic                     write;
    logic [isa_pkg::xlen-1:0] addr;
    logic [isa_pkg::xlen-1:0] wdata;
  } data_req_t;

endpackage

// ==== src/isa_pkg.sv ====
// RV32I encoding definitions for the integer subset core
// Major opcodes, funct3 and funct7 codes, data and register index widths
package isa_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================
  localparam int xlen           = 32;  // Fixed by the ISA
  localparam int reg_addr_width = 5;   // 32 architectural registers

  // Major opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,  // Register-register ALU
    opc_op_imm = 7'b0010011,  // Register-immediate ALU
    opc_lui    = 7'b0110111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111
  } opcode_e;

  // ALU funct3
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl     = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // Branch and memory funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_word = 3'b010;  // LW / SW only

  // funct7
  localparam logic [6:0] f7_base = 7'b0000000;  // ADD, SRL and the rest
  localparam logic [6:0] f7_alt  = 7'b0100000;  // SUB

endpackage
